/* source/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath and address width
`define XLEN       32
`define INSTR_W    32

// RV32E register file
`define REG_ADDR_W 4
`define NUM_REGS   16

`define RESET_PC   32'h0000_0000 // first fetch address

`endif

/* source/rv_core_pkg.sv */
package rv_core_pkg;

	// major opcodes of the kept subset
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,   // signed compare
		alu_pass_b // lui
	} alu_op_t;

	// operand source in EX
	typedef enum logic [1:0] {
		fwd_none = 2'd0,
		fwd_mem  = 2'd1, // EX/MEM alu result
		fwd_wb   = 2'd2  // writeback value
	} fwd_sel_t;

endpackage

/* source/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_fetch (
	input  logic                clock,
	input  logic                reset,
	input  logic                stall_i,
	input  logic                redirect_i,
	input  logic [`XLEN-1:0]    redirect_pc_i,
	output logic [`XLEN-1:0]    imem_addr_o,
	input  logic [`INSTR_W-1:0] imem_data_i,
	output logic [`XLEN-1:0]    if_pc_o,
	output logic [`INSTR_W-1:0] if_instr_o,
	output logic                if_valid_o
);

	logic [`XLEN-1:0] pc;

	assign imem_addr_o = pc; // instruction port answers in the same cycle

	always_ff @(posedge clock) begin
		if (reset) begin
			pc         <= `RESET_PC;
			if_valid_o <= 1'b0;
		end else if (redirect_i) begin
			pc         <= redirect_pc_i; // redirect wins over a stall
			if_valid_o <= 1'b0;          // drop the wrong-path fetch
		end else if (!stall_i) begin
			pc         <= pc + 4;
			if_valid_o <= 1'b1;
		end
	end

	// IF/ID payload
	always_ff @(posedge clock) begin
		if (!stall_i && !redirect_i) begin
			if_pc_o    <= pc;
			if_instr_o <= imem_data_i;
		end
	end

	// targets come from execute, so alignment holds across the loop
	pc_aligned: assert property (@(posedge clock) disable iff (reset)
		pc[1:0] == 2'b00);

endmodule

/* source/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decode (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   stall_i,
	input  logic                   flush_i,
	input  logic [`XLEN-1:0]       if_pc_i,
	input  logic [`INSTR_W-1:0]    if_instr_i,
	input  logic                   if_valid_i,
	input  logic                   wb_we_i,
	input  logic [`REG_ADDR_W-1:0] wb_rd_i,
	input  logic [`XLEN-1:0]       wb_data_i,
	output logic [`REG_ADDR_W-1:0] id_rs1_o,
	output logic [`REG_ADDR_W-1:0] id_rs2_o,
	output logic [`XLEN-1:0]       ex_pc_o,
	output logic [`XLEN-1:0]       ex_rs1_val_o,
	output logic [`XLEN-1:0]       ex_rs2_val_o,
	output logic [`REG_ADDR_W-1:0] ex_rs1_o,
	output logic [`REG_ADDR_W-1:0] ex_rs2_o,
	output logic [`XLEN-1:0]       ex_imm_o,
	output logic [`REG_ADDR_W-1:0] ex_rd_o,
	output rv_core_pkg::alu_op_t   ex_alu_op_o,
	output logic                   ex_use_imm_o,
	output logic                   ex_reg_write_o,
	output logic                   ex_is_load_o,
	output logic                   ex_is_store_o,
	output logic                   ex_is_branch_o,
	output logic                   ex_is_bne_o,
	output logic                   ex_is_jal_o,
	output logic                   ex_valid_o
);

	logic [`XLEN-1:0]       regs [`NUM_REGS];
	logic [`XLEN-1:0]       rs1_val, rs2_val, imm;
	logic [`REG_ADDR_W-1:0] rd;
	logic [2:0]             funct3;
	rv_core_pkg::opcode_t   opcode;
	rv_core_pkg::alu_op_t   alu_op;
	logic                   use_imm, reg_write, is_load, is_store, is_branch, is_jal;
	logic                   known_op;
	logic                   take; // instruction moves on into ID/EX

	// funct3 to alu op, sub only in register form
	function automatic rv_core_pkg::alu_op_t alu_from_funct(input logic [2:0] f3,
		input logic sub);
		case (f3)
			3'b000:  return sub ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
			3'b010:  return rv_core_pkg::alu_slt;
			3'b100:  return rv_core_pkg::alu_xor;
			3'b110:  return rv_core_pkg::alu_or;
			3'b111:  return rv_core_pkg::alu_and;
			default: return rv_core_pkg::alu_add;
		endcase
	endfunction

	assign opcode   = rv_core_pkg::opcode_t'(if_instr_i[6:0]);
	assign funct3   = if_instr_i[14:12];
	assign rd       = if_instr_i[10:7]; // RV32E, top index bit ignored
	assign id_rs1_o = if_instr_i[18:15];
	assign id_rs2_o = if_instr_i[23:20];
	assign take     = if_valid_i && !stall_i && !flush_i;

	// --------------------
	// register file
	always_ff @(posedge clock) begin
		if (wb_we_i && wb_rd_i != '0)
			regs[wb_rd_i] <= wb_data_i;
	end

	// same-cycle writeback bypass, x0 always zero
	always_comb begin
		rs1_val = regs[id_rs1_o];
		rs2_val = regs[id_rs2_o];
		if (wb_we_i && wb_rd_i == id_rs1_o)
			rs1_val = wb_data_i;
		if (wb_we_i && wb_rd_i == id_rs2_o)
			rs2_val = wb_data_i;
		if (id_rs1_o == '0)
			rs1_val = '0;
		if (id_rs2_o == '0)
			rs2_val = '0;
	end

	// --------------------
	// controls and immediates
	always_comb begin
		alu_op    = rv_core_pkg::alu_add;
		imm       = {{20{if_instr_i[31]}}, if_instr_i[31:20]}; // I form
		use_imm   = 1'b1;
		reg_write = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		known_op  = 1'b1;
		case (opcode)
			rv_core_pkg::op_lui: begin
				imm       = {if_instr_i[31:12], 12'b0};
				alu_op    = rv_core_pkg::alu_pass_b;
				reg_write = 1'b1;
			end
			rv_core_pkg::op_imm: begin
				alu_op    = alu_from_funct(funct3, 1'b0);
				reg_write = 1'b1;
			end
			rv_core_pkg::op_reg: begin
				alu_op    = alu_from_funct(funct3, if_instr_i[30]);
				use_imm   = 1'b0;
				reg_write = 1'b1;
			end
			rv_core_pkg::op_load: begin
				reg_write = 1'b1; // address is rs1 + imm
				is_load   = 1'b1;
			end
			rv_core_pkg::op_store: begin
				imm      = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
				is_store = 1'b1;
			end
			rv_core_pkg::op_branch: begin
				imm       = {{20{if_instr_i[31]}}, if_instr_i[7], if_instr_i[30:25],
					if_instr_i[11:8], 1'b0};
				use_imm   = 1'b0; // compare rs1 against rs2
				is_branch = 1'b1;
			end
			rv_core_pkg::op_jal: begin
				imm       = {{12{if_instr_i[31]}}, if_instr_i[19:12], if_instr_i[20],
					if_instr_i[30:21], 1'b0};
				reg_write = 1'b1;
				is_jal    = 1'b1;
			end
			default: known_op = 1'b0;
		endcase
	end

	// --------------------
	// ID/EX register
	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid_o     <= 1'b0;
			ex_reg_write_o <= 1'b0;
			ex_is_load_o   <= 1'b0;
			ex_is_store_o  <= 1'b0;
			ex_is_branch_o <= 1'b0;
			ex_is_jal_o    <= 1'b0;
		end else begin
			ex_valid_o     <= take; // stall and flush both leave a bubble
			ex_reg_write_o <= take && reg_write;
			ex_is_load_o   <= take && is_load;
			ex_is_store_o  <= take && is_store;
			ex_is_branch_o <= take && is_branch;
			ex_is_jal_o    <= take && is_jal;
		end
	end

	always_ff @(posedge clock) begin
		ex_pc_o      <= if_pc_i;
		ex_rs1_val_o <= rs1_val;
		ex_rs2_val_o <= rs2_val;
		ex_rs1_o     <= id_rs1_o;
		ex_rs2_o     <= id_rs2_o;
		ex_imm_o     <= imm;
		ex_rd_o      <= rd;
		ex_alu_op_o  <= alu_op;
		ex_use_imm_o <= use_imm;
		ex_is_bne_o  <= funct3[0];
	end

	// fetch only hands over words from the kept subset
	known_opcode: assert property (@(posedge clock) disable iff (reset)
		if_valid_i |-> known_op);

endmodule

/* source/rv_hazard.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_hazard (
	input  logic [`REG_ADDR_W-1:0] id_rs1_i,
	input  logic [`REG_ADDR_W-1:0] id_rs2_i,
	input  logic                   id_valid_i,
	input  logic [`REG_ADDR_W-1:0] ex_rs1_i,
	input  logic [`REG_ADDR_W-1:0] ex_rs2_i,
	input  logic [`REG_ADDR_W-1:0] ex_rd_i,
	input  logic                   ex_is_load_i,
	input  logic                   ex_reg_write_i,
	input  logic                   ex_valid_i,
	input  logic [`REG_ADDR_W-1:0] mem_rd_i,
	input  logic                   mem_is_load_i,
	input  logic                   mem_reg_write_i,
	input  logic                   mem_valid_i,
	input  logic [`REG_ADDR_W-1:0] wb_rd_i,
	input  logic                   wb_we_i,
	output rv_core_pkg::fwd_sel_t  fwd_a_o,
	output rv_core_pkg::fwd_sel_t  fwd_b_o,
	output logic                   stall_o
);

	// younger MEM writer wins over WB
	function automatic rv_core_pkg::fwd_sel_t pick_src(input logic [`REG_ADDR_W-1:0] rs);
		if (rs == '0)
			return rv_core_pkg::fwd_none;
		if (mem_valid_i && mem_reg_write_i && !mem_is_load_i && mem_rd_i == rs)
			return rv_core_pkg::fwd_mem;
		if (wb_we_i && wb_rd_i == rs)
			return rv_core_pkg::fwd_wb;
		return rv_core_pkg::fwd_none;
	endfunction

	// load data not yet back for this source
	function automatic logic load_pending(input logic [`REG_ADDR_W-1:0] rs);
		logic in_ex;
		logic in_mem;
		in_ex  = ex_valid_i && ex_is_load_i && ex_reg_write_i && ex_rd_i == rs;
		in_mem = mem_valid_i && mem_is_load_i && mem_reg_write_i && mem_rd_i == rs;
		return rs != '0 && (in_ex || in_mem);
	endfunction

	always_comb begin
		fwd_a_o = pick_src(ex_rs1_i);
		fwd_b_o = pick_src(ex_rs2_i);
		stall_o = id_valid_i && (load_pending(id_rs1_i) || load_pending(id_rs2_i));
	end

endmodule

/* source/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_execute (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`XLEN-1:0]       ex_pc_i,
	input  logic [`XLEN-1:0]       ex_rs1_val_i,
	input  logic [`XLEN-1:0]       ex_rs2_val_i,
	input  logic [`XLEN-1:0]       ex_imm_i,
	input  logic [`REG_ADDR_W-1:0] ex_rd_i,
	input  rv_core_pkg::alu_op_t   ex_alu_op_i,
	input  logic                   ex_use_imm_i,
	input  logic                   ex_reg_write_i,
	input  logic                   ex_is_load_i,
	input  logic                   ex_is_store_i,
	input  logic                   ex_is_branch_i,
	input  logic                   ex_is_bne_i,
	input  logic                   ex_is_jal_i,
	input  logic                   ex_valid_i,
	input  rv_core_pkg::fwd_sel_t  fwd_a_i,
	input  rv_core_pkg::fwd_sel_t  fwd_b_i,
	input  logic [`XLEN-1:0]       mem_fwd_data_i,
	input  logic [`XLEN-1:0]       wb_data_i,
	output logic                   redirect_o,
	output logic [`XLEN-1:0]       redirect_pc_o,
	output logic [`XLEN-1:0]       mem_pc_o,
	output logic [`XLEN-1:0]       mem_alu_o,
	output logic [`XLEN-1:0]       mem_store_data_o,
	output logic [`REG_ADDR_W-1:0] mem_rd_o,
	output logic                   mem_reg_write_o,
	output logic                   mem_is_load_o,
	output logic                   mem_is_store_o,
	output logic                   mem_valid_o
);

	logic [`XLEN-1:0] op_a, op_b, alu_b, alu_out;

	function automatic logic [`XLEN-1:0] fwd_mux(input rv_core_pkg::fwd_sel_t sel,
		input logic [`XLEN-1:0] reg_val);
		case (sel)
			rv_core_pkg::fwd_mem: return mem_fwd_data_i;
			rv_core_pkg::fwd_wb:  return wb_data_i;
			default:              return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a = fwd_mux(fwd_a_i, ex_rs1_val_i);
		op_b = fwd_mux(fwd_b_i, ex_rs2_val_i); // also the store data
	end

	assign alu_b = ex_use_imm_i ? ex_imm_i : op_b;

	// --------------------
	// ALU
	always_comb begin
		case (ex_alu_op_i)
			rv_core_pkg::alu_sub:    alu_out = op_a - alu_b;
			rv_core_pkg::alu_and:    alu_out = op_a & alu_b;
			rv_core_pkg::alu_or:     alu_out = op_a | alu_b;
			rv_core_pkg::alu_xor:    alu_out = op_a ^ alu_b;
			rv_core_pkg::alu_slt:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			rv_core_pkg::alu_pass_b: alu_out = alu_b;
			default:                 alu_out = op_a + alu_b;
		endcase
	end

	// branch resolution, taken path leaves at the end of EX
	assign redirect_o = ex_valid_i && (ex_is_jal_i ||
		(ex_is_branch_i && ((op_a == op_b) != ex_is_bne_i)));
	assign redirect_pc_o = ex_pc_i + ex_imm_i;

	// --------------------
	// EX/MEM register
	always_ff @(posedge clock) begin
		if (reset) begin
			mem_valid_o     <= 1'b0;
			mem_reg_write_o <= 1'b0;
			mem_is_load_o   <= 1'b0;
			mem_is_store_o  <= 1'b0;
		end else begin
			mem_valid_o     <= ex_valid_i;
			mem_reg_write_o <= ex_reg_write_i;
			mem_is_load_o   <= ex_is_load_i;
			mem_is_store_o  <= ex_is_store_i;
		end
	end

	always_ff @(posedge clock) begin
		mem_pc_o         <= ex_pc_i;
		mem_alu_o        <= ex_is_jal_i ? ex_pc_i + 4 : alu_out; // jal links pc+4
		mem_store_data_o <= op_b;
		mem_rd_o         <= ex_rd_i;
	end

endmodule

/* source/rv_memory.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_memory (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`XLEN-1:0]       mem_pc_i,
	input  logic [`XLEN-1:0]       mem_alu_i,
	input  logic [`XLEN-1:0]       mem_store_data_i,
	input  logic [`REG_ADDR_W-1:0] mem_rd_i,
	input  logic                   mem_reg_write_i,
	input  logic                   mem_is_load_i,
	input  logic                   mem_is_store_i,
	input  logic                   mem_valid_i,
	output logic                   dmem_we_o,
	output logic                   dmem_re_o,
	output logic [`XLEN-1:0]       dmem_addr_o,
	output logic [`XLEN-1:0]       dmem_wdata_o,
	input  logic [`XLEN-1:0]       dmem_rdata_i,
	output logic [`XLEN-1:0]       mem_fwd_data_o,
	output logic                   wb_we_o,
	output logic [`REG_ADDR_W-1:0] wb_rd_o,
	output logic [`XLEN-1:0]       wb_data_o,
	output logic                   retire_valid_o,
	output logic [`XLEN-1:0]       retire_pc_o,
	output logic [`REG_ADDR_W-1:0] retire_rd_o,
	output logic [`XLEN-1:0]       retire_data_o
);

	logic             wb_valid, wb_reg_write, wb_is_load;
	logic [`XLEN-1:0] wb_pc, wb_alu;

	// data port, whole words only
	assign dmem_we_o      = mem_valid_i && mem_is_store_i;
	assign dmem_re_o      = mem_valid_i && mem_is_load_i;
	assign dmem_addr_o    = mem_alu_i;
	assign dmem_wdata_o   = mem_store_data_i;
	assign mem_fwd_data_o = mem_alu_i;

	// --------------------
	// MEM/WB register
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid     <= 1'b0;
			wb_reg_write <= 1'b0;
			wb_is_load   <= 1'b0;
		end else begin
			wb_valid     <= mem_valid_i;
			wb_reg_write <= mem_reg_write_i;
			wb_is_load   <= mem_is_load_i;
		end
	end

	always_ff @(posedge clock) begin
		wb_pc   <= mem_pc_i;
		wb_alu  <= mem_alu_i;
		wb_rd_o <= mem_rd_i;
	end

	assign wb_we_o   = wb_valid && wb_reg_write;
	assign wb_data_o = wb_is_load ? dmem_rdata_i : wb_alu; // read data lands in WB

	// retire trace, one event per instruction
	assign retire_valid_o = wb_valid;
	assign retire_pc_o    = wb_pc;
	assign retire_rd_o    = wb_we_o ? wb_rd_o : '0; // stores and branches report x0
	assign retire_data_o  = (retire_rd_o != '0) ? wb_data_o : '0;

	// decode never marks one instruction as both load and store
	no_we_with_re: assert property (@(posedge clock) disable iff (reset)
		!(dmem_we_o && dmem_re_o));

endmodule

/* source/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_top (
	input  logic                   clock,
	input  logic                   reset,
	output logic [`XLEN-1:0]       imem_addr_o,
	input  logic [`INSTR_W-1:0]    imem_data_i,
	output logic                   dmem_we_o,
	output logic                   dmem_re_o,
	output logic [`XLEN-1:0]       dmem_addr_o,
	output logic [`XLEN-1:0]       dmem_wdata_o,
	input  logic [`XLEN-1:0]       dmem_rdata_i,
	output logic                   retire_valid_o,
	output logic [`XLEN-1:0]       retire_pc_o,
	output logic [`REG_ADDR_W-1:0] retire_rd_o,
	output logic [`XLEN-1:0]       retire_data_o
);

	// fetch and hazard
	logic [`XLEN-1:0]       if_pc, redirect_pc;
	logic [`INSTR_W-1:0]    if_instr;
	logic                   if_valid, stall, redirect;
	rv_core_pkg::fwd_sel_t  fwd_a, fwd_b;
	// ID/EX
	logic [`REG_ADDR_W-1:0] id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd;
	logic [`XLEN-1:0]       ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
	rv_core_pkg::alu_op_t   ex_alu_op;
	logic                   ex_use_imm, ex_reg_write, ex_is_load, ex_is_store;
	logic                   ex_is_branch, ex_is_bne, ex_is_jal, ex_valid;
	// EX/MEM and writeback
	logic [`XLEN-1:0]       mem_pc, mem_alu, mem_store_data, mem_fwd_data, wb_data;
	logic [`REG_ADDR_W-1:0] mem_rd, wb_rd;
	logic                   mem_reg_write, mem_is_load, mem_is_store, mem_valid, wb_we;

	rv_fetch u_fetch (
		.clock         (clock),
		.reset         (reset),
		.stall_i       (stall),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.imem_addr_o   (imem_addr_o),
		.imem_data_i   (imem_data_i),
		.if_pc_o       (if_pc),
		.if_instr_o    (if_instr),
		.if_valid_o    (if_valid)
	);

	rv_decode u_decode (
		.clock          (clock),
		.reset          (reset),
		.stall_i        (stall),
		.flush_i        (redirect), // wrong-path instruction in ID
		.if_pc_i        (if_pc),
		.if_instr_i     (if_instr),
		.if_valid_i     (if_valid),
		.wb_we_i        (wb_we),
		.wb_rd_i        (wb_rd),
		.wb_data_i      (wb_data),
		.id_rs1_o       (id_rs1),
		.id_rs2_o       (id_rs2),
		.ex_pc_o        (ex_pc),
		.ex_rs1_val_o   (ex_rs1_val),
		.ex_rs2_val_o   (ex_rs2_val),
		.ex_rs1_o       (ex_rs1),
		.ex_rs2_o       (ex_rs2),
		.ex_imm_o       (ex_imm),
		.ex_rd_o        (ex_rd),
		.ex_alu_op_o    (ex_alu_op),
		.ex_use_imm_o   (ex_use_imm),
		.ex_reg_write_o (ex_reg_write),
		.ex_is_load_o   (ex_is_load),
		.ex_is_store_o  (ex_is_store),
		.ex_is_branch_o (ex_is_branch),
		.ex_is_bne_o    (ex_is_bne),
		.ex_is_jal_o    (ex_is_jal),
		.ex_valid_o     (ex_valid)
	);

	rv_hazard u_hazard (
		.id_rs1_i        (id_rs1),
		.id_rs2_i        (id_rs2),
		.id_valid_i      (if_valid),
		.ex_rs1_i        (ex_rs1),
		.ex_rs2_i        (ex_rs2),
		.ex_rd_i         (ex_rd),
		.ex_is_load_i    (ex_is_load),
		.ex_reg_write_i  (ex_reg_write),
		.ex_valid_i      (ex_valid),
		.mem_rd_i        (mem_rd),
		.mem_is_load_i   (mem_is_load),
		.mem_reg_write_i (mem_reg_write),
		.mem_valid_i     (mem_valid),
		.wb_rd_i         (wb_rd),
		.wb_we_i         (wb_we),
		.fwd_a_o         (fwd_a),
		.fwd_b_o         (fwd_b),
		.stall_o         (stall)
	);

	rv_execute u_execute (
		.clock            (clock),
		.reset            (reset),
		.ex_pc_i          (ex_pc),
		.ex_rs1_val_i     (ex_rs1_val),
		.ex_rs2_val_i     (ex_rs2_val),
		.ex_imm_i         (ex_imm),
		.ex_rd_i          (ex_rd),
		.ex_alu_op_i      (ex_alu_op),
		.ex_use_imm_i     (ex_use_imm),
		.ex_reg_write_i   (ex_reg_write),
		.ex_is_load_i     (ex_is_load),
		.ex_is_store_i    (ex_is_store),
		.ex_is_branch_i   (ex_is_branch),
		.ex_is_bne_i      (ex_is_bne),
		.ex_is_jal_i      (ex_is_jal),
		.ex_valid_i       (ex_valid),
		.fwd_a_i          (fwd_a),
		.fwd_b_i          (fwd_b),
		.mem_fwd_data_i   (mem_fwd_data),
		.wb_data_i        (wb_data),
		.redirect_o       (redirect),
		.redirect_pc_o    (redirect_pc),
		.mem_pc_o         (mem_pc),
		.mem_alu_o        (mem_alu),
		.mem_store_data_o (mem_store_data),
		.mem_rd_o         (mem_rd),
		.mem_reg_write_o  (mem_reg_write),
		.mem_is_load_o    (mem_is_load),
		.mem_is_store_o   (mem_is_store),
		.mem_valid_o      (mem_valid)
	);

	rv_memory u_memory (
		.clock            (clock),
		.reset            (reset),
		.mem_pc_i         (mem_pc),
		.mem_alu_i        (mem_alu),
		.mem_store_data_i (mem_store_data),
		.mem_rd_i         (mem_rd),
		.mem_reg_write_i  (mem_reg_write),
		.mem_is_load_i    (mem_is_load),
		.mem_is_store_i   (mem_is_store),
		.mem_valid_i      (mem_valid),
		.dmem_we_o        (dmem_we_o),
		.dmem_re_o        (dmem_re_o),
		.dmem_addr_o      (dmem_addr_o),
		.dmem_wdata_o     (dmem_wdata_o),
		.dmem_rdata_i     (dmem_rdata_i),
		.mem_fwd_data_o   (mem_fwd_data),
		.wb_we_o          (wb_we),
		.wb_rd_o          (wb_rd),
		.wb_data_o        (wb_data),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o)
	);

endmodule

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module tb_rv_core;

	localparam int prog_len  = 200;
	localparam int max_exp   = 1024;
	localparam int run_limit = 5000; // cycles after reset
	localparam logic [31:0] self_pc = 32'((prog_len - 1) * 4);
	localparam int kind_alu    = 0;
	localparam int kind_load   = 1;
	localparam int kind_store  = 2;
	localparam int kind_branch = 3;
	localparam int kind_jal    = 4;

	logic                   clock, reset;
	logic [`XLEN-1:0]       imem_addr, dmem_addr, dmem_wdata, dmem_rdata;
	logic [`INSTR_W-1:0]    imem_data;
	logic                   dmem_we, dmem_re, retire_valid;
	logic [`XLEN-1:0]       retire_pc, retire_data;
	logic [`REG_ADDR_W-1:0] retire_rd;

	logic [31:0] imem [256];
	logic [31:0] dmem [64];       // written by the DUT
	logic [31:0] model_dmem [64]; // written by the reference model
	logic [31:0] read_pending;
	logic [31:0] rng_state;

	// expected retire and store streams
	logic [31:0] exp_pc [max_exp];
	logic [3:0]  exp_rd [max_exp];
	logic [31:0] exp_val [max_exp];
	int          exp_kind [max_exp];
	logic [31:0] exp_st_addr [max_exp];
	logic [31:0] exp_st_data [max_exp];
	int          exp_count, exp_st_count, ret_idx, st_idx;
	int          err [1:6];
	bit          run_done;

	rv_core_top dut (
		.clock          (clock),
		.reset          (reset),
		.imem_addr_o    (imem_addr),
		.imem_data_i    (imem_data),
		.dmem_we_o      (dmem_we),
		.dmem_re_o      (dmem_re),
		.dmem_addr_o    (dmem_addr),
		.dmem_wdata_o   (dmem_wdata),
		.dmem_rdata_i   (dmem_rdata),
		.retire_valid_o (retire_valid),
		.retire_pc_o    (retire_pc),
		.retire_rd_o    (retire_rd),
		.retire_data_o  (retire_data)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// --------------------
	// random numbers and encoders
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [3:0] rs1,
		input logic [2:0] f3, input logic [3:0] rd, input logic [6:0] op);
		return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [3:0] rs2,
		input logic [3:0] rs1, input logic [2:0] f3, input logic [3:0] rd);
		return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] off, input logic [3:0] rs2);
		return {off[11:5], 1'b0, rs2, 5'd0, 3'b010, off[4:0], 7'b0100011}; // base x0
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [3:0] rs2,
		input logic [3:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [3:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, 7'b1101111};
	endfunction

	// funct3 of add, and, or, xor, slt
	function automatic logic [2:0] alu_f3(input int sel);
		case (sel)
			1:       return 3'b111;
			2:       return 3'b110;
			3:       return 3'b100;
			4:       return 3'b010;
			default: return 3'b000;
		endcase
	endfunction

	function automatic logic [31:0] dmem_fill(input int i);
		return 32'hc0de_0000 ^ (32'(i) * 32'h0004_1d21) ^ 32'(i);
	endfunction

	// --------------------
	// random program
	task automatic build_program();
		logic [31:0] r, r2;
		logic [3:0]  rd, rs1, rs2, prev_rd;
		int          kind, skip, sel;
		prev_rd = 4'd1;
		for (int i = 0; i < 15; i++) begin
			r = next_rand();
			imem[i] = {r[31:12], 1'b0, 4'(i + 1), 7'b0110111}; // lui seeds every register
		end
		for (int i = 15; i < prog_len - 1; i++) begin
			r    = next_rand();
			r2   = next_rand();
			kind = int'(r[7:0]) % 100;
			rd   = 4'(int'(r[15:8]) % 15) + 4'd1;
			rs1  = (r[18:16] < 3'd3) ? prev_rd : 4'(int'(r[27:20]) % 15) + 4'd1;
			rs2  = (r[30:29] == 2'd0) ? prev_rd : 4'(int'(r2[31:24]) % 15) + 4'd1;
			skip = 1 + int'(r2[1:0]);
			if (i + skip > prog_len - 1)
				skip = prog_len - 1 - i;
			if (kind < 10) begin
				imem[i] = {r2[31:12], 1'b0, rd, 7'b0110111};
			end else if (kind < 35) begin
				sel     = int'(r2[2:0]) % 5;
				imem[i] = enc_i(r2[23:12], rs1, alu_f3(sel), rd, 7'b0010011);
			end else if (kind < 60) begin
				sel     = int'(r2[5:3]) % 6; // 5 is sub
				imem[i] = enc_r((sel == 5) ? 7'h20 : 7'h00, rs2, rs1,
					(sel == 5) ? 3'b000 : alu_f3(sel), rd);
			end else if (kind < 72) begin
				imem[i] = enc_i({4'b0, r2[7:2], 2'b00}, 4'd0, 3'b010, rd, 7'b0000011);
			end else if (kind < 82) begin
				imem[i] = enc_s({4'b0, r2[7:2], 2'b00}, rs1);
			end else if (kind < 94) begin
				imem[i] = enc_b(13'(skip * 4), r2[2] ? rs1 : rs2, rs1, {2'b00, r2[3]});
			end else begin
				imem[i] = enc_j(21'(skip * 4), rd);
			end
			if (kind < 72 || kind >= 94)
				prev_rd = rd; // only register writers start a chain
		end
		imem[prog_len - 1] = enc_j(21'd0, 4'd0); // jump to itself
		for (int i = prog_len; i < 256; i++)
			imem[i] = enc_i(12'(i), 4'd0, 3'b000, 4'd0, 7'b0010011);
	endtask

	// --------------------
	// reference model
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic run_model();
		logic [31:0] regs [16];
		logic [31:0] pc, next_pc, ins, a, b, val, addr;
		logic [3:0]  rd;
		int          kind;
		bit          stop;
		for (int i = 0; i < 16; i++)
			regs[i] = 32'd0;
		pc   = `RESET_PC;
		stop = 1'b0;
		while (!stop && exp_count < max_exp) begin
			ins     = imem[pc[9:2]];
			rd      = ins[10:7];
			a       = regs[ins[18:15]];
			b       = regs[ins[23:20]];
			val     = 32'd0;
			kind    = kind_alu;
			next_pc = pc + 32'd4;
			case (ins[6:0])
				7'b0110111: val = {ins[31:12], 12'b0};
				7'b0010011: val = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
				7'b0110011: val = alu_ref(ins[14:12], ins[30], a, b);
				7'b0000011: begin
					kind = kind_load;
					addr = a + {{20{ins[31]}}, ins[31:20]};
					val  = model_dmem[addr[7:2]];
				end
				7'b0100011: begin
					kind = kind_store;
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					model_dmem[addr[7:2]]     = b;
					exp_st_addr[exp_st_count] = addr;
					exp_st_data[exp_st_count] = b;
					exp_st_count++;
				end
				7'b1100011: begin
					kind = kind_branch;
					if ((a == b) != ins[12])
						next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				default: begin
					kind    = kind_jal;
					val     = pc + 32'd4;
					next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
			endcase
			if (kind == kind_store || kind == kind_branch)
				rd = 4'd0;
			if (rd == 4'd0)
				val = 32'd0;
			else
				regs[rd] = val;
			exp_pc[exp_count]   = pc;
			exp_rd[exp_count]   = rd;
			exp_val[exp_count]  = val;
			exp_kind[exp_count] = kind;
			exp_count++;
			stop = (pc == self_pc);
			pc   = next_pc;
		end
	endtask

	// --------------------
	// memories and monitors
	always @(negedge clock) begin
		imem_data  = imem[imem_addr[9:2]];
		dmem_rdata = read_pending; // read answered one cycle after the request
	end

	task automatic check_store();
		if (st_idx >= exp_st_count) begin
			err[5]++;
			$display("ERROR at %0t ns: store to %h beyond the model's %0d stores",
				$time, dmem_addr, exp_st_count);
		end else if (dmem_addr !== exp_st_addr[st_idx] || dmem_wdata !== exp_st_data[st_idx]) begin
			err[5]++;
			$display("ERROR at %0t ns: store %0d wrote %h to %h, expected %h to %h", $time,
				st_idx, dmem_wdata, dmem_addr, exp_st_data[st_idx], exp_st_addr[st_idx]);
		end
		st_idx++;
	endtask

	task automatic check_retire();
		int t;
		if (ret_idx >= exp_count) begin
			err[6]++;
			$display("ERROR at %0t ns: retire at pc %h beyond the model's %0d instructions",
				$time, retire_pc, exp_count);
		end else if (retire_pc !== exp_pc[ret_idx]) begin
			err[4]++;
			$display("ERROR at %0t ns: retire %0d at pc %h, expected pc %h",
				$time, ret_idx, retire_pc, exp_pc[ret_idx]);
		end else begin
			case (exp_kind[ret_idx])
				kind_load:  t = 3;
				kind_store: t = 5;
				kind_alu:   t = 2;
				default:    t = 4; // branches and jal
			endcase
			if (retire_rd !== exp_rd[ret_idx] || retire_data !== exp_val[ret_idx]) begin
				err[t]++;
				$display("ERROR at %0t ns: pc %h wrote x%0d = %h, expected x%0d = %h", $time,
					retire_pc, retire_rd, retire_data, exp_rd[ret_idx], exp_val[ret_idx]);
			end
		end
		if (retire_rd == 4'd0 && retire_data !== 32'd0) begin
			err[6]++;
			$display("ERROR at %0t ns: x0 retired with value %h", $time, retire_data);
		end
		if (retire_pc == self_pc)
			run_done = 1'b1;
		ret_idx++;
	endtask

	// outputs sampled at the rising edge, before the pipeline moves
	always @(posedge clock) begin
		if (!reset && !run_done) begin
			if (dmem_we) begin
				check_store();
				dmem[dmem_addr[7:2]] = dmem_wdata;
			end
			if (dmem_re)
				read_pending = dmem[dmem_addr[7:2]];
			if (retire_valid)
				check_retire();
		end
	end

	task automatic report_test(input int n, input string what);
		if (err[n] == 0)
			$display("test %0d %s: ok", n, what);
		else
			$display("test %0d %s: %0d errors", n, what, err[n]);
	endtask

	task automatic check_reset_outputs();
		if (retire_valid !== 1'b0 || dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
			err[1]++;
			$display("ERROR at %0t ns: retire/we/re = %b%b%b around reset", $time,
				retire_valid, dmem_we, dmem_re);
		end
	endtask

	// --------------------
	// main sequence
	initial begin
		int cycles;
		int total;
		reset        = 1'b1;
		imem_data    = 32'h0000_0013; // addi x0, x0, 0
		dmem_rdata   = 32'd0;
		read_pending = 32'd0;
		rng_state    = 32'd58;
		run_done     = 1'b0;
		exp_count    = 0;
		exp_st_count = 0;
		ret_idx      = 0;
		st_idx       = 0;
		for (int i = 1; i <= 6; i++)
			err[i] = 0;
		for (int i = 0; i < 64; i++) begin
			dmem[i]       = dmem_fill(i);
			model_dmem[i] = dmem_fill(i);
		end
		build_program();
		run_model();

		for (int c = 0; c < 8; c++) begin
			@(negedge clock);
			check_reset_outputs();
			if (imem_addr !== `RESET_PC) begin
				err[1]++;
				$display("ERROR at %0t ns: fetch address %h in reset", $time, imem_addr);
			end
		end
		reset = 1'b0;
		@(negedge clock);
		check_reset_outputs(); // first cycle out of reset
		report_test(1, "reset outputs and first fetch");

		cycles = 0;
		while (!run_done && cycles < run_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (!run_done) begin
			$display("timeout: the self-loop at pc %h did not retire within %0d cycles",
				self_pc, run_limit);
			$display("TEST FAIL");
			$finish;
		end else begin
			for (int i = 0; i < 64; i++) begin
				if (dmem[i] !== model_dmem[i]) begin
					err[5]++;
					$display("ERROR at %0t ns: data word %0d is %h, expected %h",
						$time, i, dmem[i], model_dmem[i]);
				end
			end
			if (st_idx != exp_st_count) begin
				err[5]++;
				$display("ERROR at %0t ns: %0d stores seen, expected %0d",
					$time, st_idx, exp_st_count);
			end
			if (ret_idx != exp_count) begin
				err[6]++;
				$display("ERROR at %0t ns: %0d retired, expected %0d", $time, ret_idx, exp_count);
			end
			report_test(2, "alu and lui results");
			report_test(3, "load results");
			report_test(4, "taken path and jal link");
			report_test(5, "stores and final data array");
			report_test(6, "x0 and retire count");
			total = err[1] + err[2] + err[3] + err[4] + err[5] + err[6];
			$display("summary: %0d retired, %0d stores, %0d errors", ret_idx, st_idx, total);
			if (total == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

endmodule

/* compile.f */
+incdir+source
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_hazard.sv
source/rv_execute.sv
source/rv_memory.sv
source/rv_core_top.sv
tb/tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
